// File: bootSoc_defines.svh
`ifndef BOOTSOC_DEFINES_SVH
`define BOOTSOC_DEFINES_SVH

// Program RAM depth in 32-bit words
`define RAM_WORDS 1024

// Framebuffer is FB_SIZE rows by FB_SIZE columns
`define FB_SIZE 256

// Card read command byte
`define CARD_READ_CMD 8'h03

// Boot register offsets
`define REG_CONTROL 8'h00
`define REG_BASE    8'h04
`define REG_STATUS  8'h08
`define REG_COUNT   8'h0C

`endif

// File: bootSocPkg.sv
package bootSocPkg;

    // One data address word, decoded as a RAM word or as a pixel coordinate
    typedef union packed {
        struct packed {
            logic [15:0] upper;
            logic [15:0] wordIndex;
        } ramView;
        struct packed {
            logic [7:0]  row;
            logic [7:0]  col;
            logic [15:0] low;
        } pixelView;
    } dataAddr;

    // Processor data bus
    typedef struct packed {
        dataAddr     addr;
        logic [31:0] writeData;
        logic        writeEn;
        logic        readEn;
    } cpuBus;

    // Loader to card reader
    typedef struct packed {
        logic        read;
        logic [23:0] addr;
    } cardReq;

    // Card reader to loader
    typedef struct packed {
        logic        busy;
        logic        wordValid;
        logic [31:0] word;
    } cardRsp;

    // Loader write port into program RAM
    typedef struct packed {
        logic        writeEn;
        logic [15:0] addr;
        logic [31:0] data;
    } ramWrite;

    typedef struct packed {
        logic        busy;
        logic        done;
        logic        sizeError;
        logic [16:0] wordsLoaded;
    } bootStatus;

endpackage

// File: sdWordReader.sv
`timescale 1ns/1ps
`include "bootSoc_defines.svh"

module sdWordReader (
    input  logic               clk_25mhz,
    input  logic               reset,
    input  bootSocPkg::cardReq req,
    output bootSocPkg::cardRsp rsp,
    output logic               cs,
    output logic               sclk,
    output logic               mosi,
    input  logic               miso
);

    // Tick schedule of one read, counted from the cycle after the strobe
    localparam logic [7:0] selectTick = 8'd0;
    localparam logic [7:0] clockFirst = 8'd1;
    localparam logic [7:0] clockLast  = 8'd128;
    localparam logic [7:0] finishTick = 8'd130;

    logic        busy;
    logic        wordValid;
    logic [7:0]  tick;
    logic        sclkActive;
    logic        strobeTaken;
    logic [31:0] txShift;
    logic [31:0] rxShift;
    logic [31:0] word;

    assign strobeTaken = !busy && req.read;
    assign sclkActive  = busy && (tick >= clockFirst) && (tick <= clockLast);

    // Command and address leave MSB first
    assign mosi = txShift[31];

    assign rsp.busy      = busy;
    assign rsp.wordValid = wordValid;
    assign rsp.word      = word;

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            busy      <= 1'b0;
            wordValid <= 1'b0;
            cs        <= 1'b1;
            sclk      <= 1'b0;
            tick      <= 8'd0;
        end else begin
            wordValid <= 1'b0;
            if (strobeTaken) begin
                busy <= 1'b1;
                tick <= 8'd0;
            end else if (busy) begin
                tick <= tick + 8'd1;
                if (tick == selectTick) begin
                    cs <= 1'b0;
                end
                if (sclkActive) begin
                    sclk <= ~sclk;
                end
                if (tick == finishTick) begin
                    cs        <= 1'b1;
                    busy      <= 1'b0;
                    wordValid <= 1'b1;
                end
            end
        end
    end

    // Shift out on falling sclk, sample miso on rising sclk
    always_ff @(posedge clk_25mhz) begin
        if (strobeTaken) begin
            txShift <= {`CARD_READ_CMD, req.addr};
        end else if (sclkActive) begin
            if (sclk) begin
                txShift <= {txShift[30:0], 1'b0};
            end else begin
                rxShift <= {rxShift[30:0], miso};
            end
        end
        // Only the last 32 samples remain, which is the data word
        if (busy && tick == finishTick) begin
            word <= rxShift;
        end
    end

endmodule

// File: bootLoader.sv
`timescale 1ns/1ps
`include "bootSoc_defines.svh"

module bootLoader (
    input  logic                  clk_25mhz,
    input  logic                  reset,
    input  logic                  start,
    input  logic [23:0]           cardBase,
    output bootSocPkg::cardReq    cardReqOut,
    input  bootSocPkg::cardRsp    cardRspIn,
    output bootSocPkg::ramWrite   ramPort,
    output bootSocPkg::bootStatus status,
    output logic                  cpuHold
);

    typedef enum logic [2:0] {
        stIdle,
        stReadCount,
        stCheckSize,
        stLoadWords,
        stDone,
        stError
    } loaderState;

    loaderState  state;
    logic        readStrobe;
    logic [23:0] cardAddr;
    logic [31:0] wordCount;
    logic [16:0] wordsLoaded;
    logic        done;
    logic        sizeError;
    logic        wordArrived;

    assign wordArrived = (state == stLoadWords) && cardRspIn.wordValid;

    assign cardReqOut.read = readStrobe;
    assign cardReqOut.addr = cardAddr;

    // Each image word goes to RAM in the cycle it arrives
    assign ramPort.writeEn = wordArrived;
    assign ramPort.addr    = wordsLoaded[15:0];
    assign ramPort.data    = cardRspIn.word;

    assign status.busy = (state == stReadCount) || (state == stCheckSize) ||
                         (state == stLoadWords);
    assign status.done        = done;
    assign status.sizeError   = sizeError;
    assign status.wordsLoaded = wordsLoaded;

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            state       <= stIdle;
            readStrobe  <= 1'b0;
            wordsLoaded <= 17'd0;
            done        <= 1'b0;
            sizeError   <= 1'b0;
            cpuHold     <= 1'b1;
        end else begin
            readStrobe <= 1'b0;
            case (state)
                stIdle, stDone, stError: begin
                    if (start) begin
                        // Count word sits at the base address
                        cardAddr    <= cardBase;
                        readStrobe  <= 1'b1;
                        wordsLoaded <= 17'd0;
                        done        <= 1'b0;
                        sizeError   <= 1'b0;
                        cpuHold     <= 1'b1;
                        state       <= stReadCount;
                    end
                end
                stReadCount: begin
                    if (cardRspIn.wordValid) begin
                        wordCount <= cardRspIn.word;
                        state     <= stCheckSize;
                    end
                end
                stCheckSize: begin
                    if (wordCount > 32'(`RAM_WORDS)) begin
                        sizeError <= 1'b1;
                        state     <= stError;
                    end else if (wordCount == 32'd0) begin
                        done    <= 1'b1;
                        cpuHold <= 1'b0;
                        state   <= stDone;
                    end else begin
                        cardAddr   <= cardAddr + 24'd1;
                        readStrobe <= 1'b1;
                        state      <= stLoadWords;
                    end
                end
                stLoadWords: begin
                    if (wordArrived) begin
                        wordsLoaded <= wordsLoaded + 17'd1;
                        if ({15'd0, wordsLoaded} + 32'd1 == wordCount) begin
                            done    <= 1'b1;
                            cpuHold <= 1'b0;
                            state   <= stDone;
                        end else begin
                            cardAddr   <= cardAddr + 24'd1;
                            readStrobe <= 1'b1;
                        end
                    end
                end
                default: state <= stIdle;
            endcase
        end
    end

endmodule

// File: bootRegs.sv
`timescale 1ns/1ps
`include "bootSoc_defines.svh"

module bootRegs (
    input  logic                  clk_25mhz,
    input  logic                  reset,
    input  logic [7:0]            awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  logic [31:0]           wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output logic [1:0]            bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  logic [7:0]            araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output logic [31:0]           rdata,
    output logic [1:0]            rresp,
    output logic                  rvalid,
    input  logic                  rready,
    output logic                  start,
    output logic [23:0]           cardBase,
    input  bootSocPkg::bootStatus status
);

    logic        writeFire;
    logic        readFire;
    logic [31:0] readValue;

    // Address and data are taken together, and only with no response pending
    assign writeFire = awvalid && wvalid && !bvalid;
    assign awready   = writeFire;
    assign wready    = writeFire;
    assign arready   = !rvalid;
    assign readFire  = arvalid && arready;

    // Always OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    always_comb begin
        case (araddr)
            `REG_BASE:   readValue = {8'd0, cardBase};
            `REG_STATUS: readValue = {29'd0, status.sizeError, status.done, status.busy};
            `REG_COUNT:  readValue = {15'd0, status.wordsLoaded};
            default:     readValue = 32'd0;
        endcase
    end

    always_ff @(posedge clk_25mhz) begin
        if (reset) begin
            bvalid   <= 1'b0;
            rvalid   <= 1'b0;
            start    <= 1'b0;
            cardBase <= 24'd0;
        end else begin
            start <= 1'b0;
            if (writeFire) begin
                bvalid <= 1'b1;
                if (awaddr == `REG_CONTROL && wstrb[0] && wdata[0] && !status.busy) begin
                    start <= 1'b1;
                end
                if (awaddr == `REG_BASE) begin
                    for (int i = 0; i < 3; i++) begin
                        if (wstrb[i]) begin
                            cardBase[i*8 +: 8] <= wdata[i*8 +: 8];
                        end
                    end
                end
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (readFire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (readFire) begin
            rdata <= readValue;
        end
    end

endmodule

// File: programMemory.sv
`timescale 1ns/1ps
`include "bootSoc_defines.svh"

module programMemory (
    input  logic                clk_25mhz,
    input  logic                cpuHold,
    input  bootSocPkg::ramWrite loaderPort,
    input  bootSocPkg::cpuBus   bus,
    output logic [31:0]         readData
);

    localparam int addrBits = $clog2(`RAM_WORDS);

    logic [31:0]         mem [`RAM_WORDS];
    logic                inRam;
    logic [addrBits-1:0] cpuIndex;
    logic                writeEn;
    logic [addrBits-1:0] writeAddr;
    logic [31:0]         writeData;

    // RAM view with the index inside the array
    assign inRam = (bus.addr.ramView.upper == 16'd0) &&
                   (bus.addr.ramView.wordIndex[15:addrBits] == '0);
    assign cpuIndex = bus.addr.ramView.wordIndex[addrBits-1:0];

    // Loader owns the write port while the processor is held
    always_comb begin
        if (cpuHold) begin
            writeEn   = loaderPort.writeEn;
            writeAddr = loaderPort.addr[addrBits-1:0];
            writeData = loaderPort.data;
        end else begin
            writeEn   = bus.writeEn && inRam;
            writeAddr = cpuIndex;
            writeData = bus.writeData;
        end
    end

    always_ff @(posedge clk_25mhz) begin
        if (writeEn) begin
            mem[writeAddr] <= writeData;
        end
        if (!cpuHold && bus.readEn && inRam) begin
            readData <= mem[cpuIndex];
        end
    end

endmodule

// File: frameBuffer.sv
`timescale 1ns/1ps
`include "bootSoc_defines.svh"

module frameBuffer (
    input  logic              clk_25mhz,
    input  bootSocPkg::cpuBus bus,
    input  logic [7:0]        pixelRow,
    input  logic [7:0]        pixelCol,
    output logic [7:0]        pixelColor
);

    localparam int pixelCount = `FB_SIZE * `FB_SIZE;

    logic [7:0]  pixels [pixelCount];
    logic        inFrame;
    logic [15:0] writeIndex;

    // Zero row and column together mean a RAM address
    assign inFrame    = {bus.addr.pixelView.row, bus.addr.pixelView.col} != 16'd0;
    assign writeIndex = {bus.addr.pixelView.row, bus.addr.pixelView.col};

    always_ff @(posedge clk_25mhz) begin
        if (bus.writeEn && inFrame) begin
            pixels[writeIndex] <= bus.writeData[7:0];
        end
        // Display read, one cycle latency
        pixelColor <= pixels[{pixelRow, pixelCol}];
    end

endmodule

// File: bootSocTop.sv
`timescale 1ns/1ps

module bootSocTop (
    input  logic              clk_25mhz,
    input  logic              reset,
    input  logic [7:0]        awaddr,
    input  logic              awvalid,
    output logic              awready,
    input  logic [31:0]       wdata,
    input  logic [3:0]        wstrb,
    input  logic              wvalid,
    output logic              wready,
    output logic [1:0]        bresp,
    output logic              bvalid,
    input  logic              bready,
    input  logic [7:0]        araddr,
    input  logic              arvalid,
    output logic              arready,
    output logic [31:0]       rdata,
    output logic [1:0]        rresp,
    output logic              rvalid,
    input  logic              rready,
    input  bootSocPkg::cpuBus cpuIn,
    output logic [31:0]       cpuReadData,
    output logic              cpuHold,
    output logic              sdCs,
    output logic              sdClk,
    output logic              sdMosi,
    input  logic              sdMiso,
    input  logic [7:0]        pixelRow,
    input  logic [7:0]        pixelCol,
    output logic [7:0]        pixelColor
);

    import bootSocPkg::*;

    logic        startPulse;
    logic [23:0] cardBase;
    bootStatus   loaderStatus;
    cardReq      cardRequest;
    cardRsp      cardResponse;
    ramWrite     loaderWrite;

    bootRegs regs (
        .clk_25mhz(clk_25mhz), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .start(startPulse), .cardBase(cardBase), .status(loaderStatus)
    );

    bootLoader loader (
        .clk_25mhz(clk_25mhz), .reset(reset),
        .start(startPulse), .cardBase(cardBase),
        .cardReqOut(cardRequest), .cardRspIn(cardResponse),
        .ramPort(loaderWrite), .status(loaderStatus), .cpuHold(cpuHold)
    );

    sdWordReader reader (
        .clk_25mhz(clk_25mhz), .reset(reset),
        .req(cardRequest), .rsp(cardResponse),
        .cs(sdCs), .sclk(sdClk), .mosi(sdMosi), .miso(sdMiso)
    );

    programMemory ram (
        .clk_25mhz(clk_25mhz), .cpuHold(cpuHold),
        .loaderPort(loaderWrite), .bus(cpuIn), .readData(cpuReadData)
    );

    frameBuffer fb (
        .clk_25mhz(clk_25mhz), .bus(cpuIn),
        .pixelRow(pixelRow), .pixelCol(pixelCol), .pixelColor(pixelColor)
    );

endmodule

// File: bootSoc_props.sv
`timescale 1ns/1ps

module bootSocProps (
    input logic clk_25mhz,
    input logic reset,
    input logic sdCs,
    input logic readerBusy,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic cpuHold,
    input logic statusDone
);

    int assertFailures = 0;

    // Card deselected whenever no read is in flight
    csIdle: assert property (@(posedge clk_25mhz) disable iff (reset)
        !readerBusy |-> sdCs)
        else begin
            assertFailures++;
            $error("card select low while reader idle");
        end

    bvalidHeld: assert property (@(posedge clk_25mhz) disable iff (reset)
        bvalid && !bready |=> bvalid)
        else begin
            assertFailures++;
            $error("bvalid dropped before bready");
        end

    rvalidHeld: assert property (@(posedge clk_25mhz) disable iff (reset)
        rvalid && !rready |=> rvalid)
        else begin
            assertFailures++;
            $error("rvalid dropped before rready");
        end

    // Hold only released at the end of a good load
    holdRelease: assert property (@(posedge clk_25mhz) disable iff (reset)
        $fell(cpuHold) |-> statusDone)
        else begin
            assertFailures++;
            $error("cpuHold fell without status done");
        end

endmodule

bind bootSocTop bootSocProps props (
    .clk_25mhz(clk_25mhz), .reset(reset), .sdCs(sdCs),
    .readerBusy(cardResponse.busy),
    .bvalid(bvalid), .bready(bready), .rvalid(rvalid), .rready(rready),
    .cpuHold(cpuHold), .statusDone(loaderStatus.done)
);

// File: bootSocTb.sv
`timescale 1ns/1ps
`include "bootSoc_defines.svh"

module bootSocTb;

    import bootSocPkg::*;

    localparam int handshakeLimit = 50;
    localparam int pollLimit      = 20000;

    logic        clk_25mhz;
    logic        reset;
    logic [7:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [7:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    cpuBus       cpuIn;
    logic [31:0] cpuReadData;
    logic        cpuHold;
    logic        sdCs;
    logic        sdClk;
    logic        sdMosi;
    logic        sdMiso;
    logic [7:0]  pixelRow;
    logic [7:0]  pixelCol;
    logic [7:0]  pixelColor;

    // Card contents, indexed by the low byte of the card word address
    logic [31:0] cardImage [256];
    int          cardBitCount;
    logic [31:0] cardCommand;
    logic [31:0] cardData;

    bootSocTop uut (
        .clk_25mhz(clk_25mhz), .reset(reset),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .cpuIn(cpuIn), .cpuReadData(cpuReadData), .cpuHold(cpuHold),
        .sdCs(sdCs), .sdClk(sdClk), .sdMosi(sdMosi), .sdMiso(sdMiso),
        .pixelRow(pixelRow), .pixelCol(pixelCol), .pixelColor(pixelColor)
    );

    always #20 clk_25mhz = ~clk_25mhz;

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic checkValue(input string testName, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            stopWithFailure($sformatf("Mismatch in %s: expected %h, actual %h",
                                      testName, expected, actual));
        end
    endtask

    // Image word for RAM index: count sits at base, data starts at base+1
    function automatic logic [31:0] expectedRamWord(input int index, input logic [23:0] base);
        logic [7:0] slot;
        slot = base[7:0] + 8'd1 + index[7:0];
        return cardImage[slot];
    endfunction

    function automatic dataAddr ramAddress(input logic [15:0] index);
        dataAddr a;
        a.ramView.upper     = 16'd0;
        a.ramView.wordIndex = index;
        return a;
    endfunction

    function automatic dataAddr pixelAddress(input logic [7:0] row, input logic [7:0] col,
                                             input logic [15:0] low);
        dataAddr a;
        a.pixelView.row = row;
        a.pixelView.col = col;
        a.pixelView.low = low;
        return a;
    endfunction

    task automatic stepCycle();
        @(posedge clk_25mhz);
        #2;
    endtask

    task automatic writeReg(input logic [7:0] addr, input logic [31:0] data);
        int cycles;
        cycles  = 0;
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hF;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // awready follows awvalid within the cycle
        #1;
        while (!awready) begin
            stepCycle();
            cycles++;
            if (cycles > handshakeLimit) stopWithFailure("AXI write address was never accepted");
        end
        stepCycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        cycles  = 0;
        while (!bvalid) begin
            stepCycle();
            cycles++;
            if (cycles > handshakeLimit) stopWithFailure("AXI write response never arrived");
        end
        checkValue("write response", 32'd0, {30'd0, bresp});
        stepCycle();
        bready = 1'b0;
    endtask

    task automatic readReg(input logic [7:0] addr, output logic [31:0] data);
        int cycles;
        cycles  = 0;
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) begin
            stepCycle();
            cycles++;
            if (cycles > handshakeLimit) stopWithFailure("AXI read address was never accepted");
        end
        stepCycle();
        arvalid = 1'b0;
        rready  = 1'b1;
        cycles  = 0;
        while (!rvalid) begin
            stepCycle();
            cycles++;
            if (cycles > handshakeLimit) stopWithFailure("AXI read data never arrived");
        end
        data = rdata;
        checkValue("read response", 32'd0, {30'd0, rresp});
        stepCycle();
        rready = 1'b0;
    endtask

    task automatic writeBus(input dataAddr addr, input logic [31:0] data);
        cpuIn.addr      = addr;
        cpuIn.writeData = data;
        cpuIn.writeEn   = 1'b1;
        stepCycle();
        cpuIn.writeEn = 1'b0;
    endtask

    // RAM data is registered, valid right after the edge that took readEn
    task automatic readRamWord(input int index, output logic [31:0] data);
        cpuIn.addr   = ramAddress(16'(index));
        cpuIn.readEn = 1'b1;
        stepCycle();
        cpuIn.readEn = 1'b0;
        data = cpuReadData;
    endtask

    task automatic startBoot(input logic [23:0] base);
        writeReg(`REG_BASE, {8'd0, base});
        writeReg(`REG_CONTROL, 32'd1);
    endtask

    // Poll until done or sizeError is set
    task automatic pollUntilFinished(output logic [31:0] finalStatus);
        int polls;
        logic [31:0] value;
        polls = 0;
        readReg(`REG_STATUS, value);
        while ((value & 32'h6) == 32'd0) begin
            polls++;
            if (polls > pollLimit) stopWithFailure("Boot never reported done or size error");
            readReg(`REG_STATUS, value);
        end
        finalStatus = value;
    endtask

    task automatic checkRamRange(input string testName, input int first, input int last,
                                 input logic [23:0] base);
        logic [31:0] value;
        for (int i = first; i <= last; i++) begin
            readRamWord(i, value);
            checkValue($sformatf("%s word %0d", testName, i), expectedRamWord(i, base), value);
        end
    endtask

    // Card model: 32 bits in on rising sclk, data out on falling sclk
    always @(negedge sdCs) begin
        cardBitCount = 0;
    end

    always @(posedge sdClk) begin
        if (!sdCs) begin
            if (cardBitCount < 32) cardCommand = {cardCommand[30:0], sdMosi};
            cardBitCount++;
        end
    end

    always @(negedge sdClk) begin
        if (!sdCs && cardBitCount >= 32) begin
            if (cardBitCount == 32) begin
                if (cardCommand[31:24] != `CARD_READ_CMD) begin
                    stopWithFailure("Card received a command byte other than read");
                end
                cardData = cardImage[cardCommand[7:0]];
            end else begin
                cardData = {cardData[30:0], 1'b0};
            end
            #2;
            sdMiso = cardData[31];
        end
    end

    always @(posedge clk_25mhz) begin
        if (uut.props.assertFailures != 0) stopWithFailure("A bound assertion on the DUT failed");
    end

    initial begin
        logic [31:0] value;
        void'($urandom(32'h1d50451b));
        for (int i = 0; i < 256; i++) cardImage[i] = $urandom;
        cardImage[16]  = 32'd40;
        cardImage[100] = 32'd2000;
        cardImage[200] = 32'd12;

        clk_25mhz = 1'b0;
        reset     = 1'b1;
        awaddr    = 8'd0;
        awvalid   = 1'b0;
        wdata     = 32'd0;
        wstrb     = 4'h0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = 8'd0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        cpuIn     = '0;
        sdMiso    = 1'b0;
        pixelRow  = 8'd0;
        pixelCol  = 8'd0;
        repeat (10) @(posedge clk_25mhz);
        #2;
        reset = 1'b0;

        // Reset state and register access
        checkValue("hold after reset", 32'd1, {31'd0, cpuHold});
        readReg(`REG_STATUS, value);
        checkValue("status after reset", 32'd0, value);
        readReg(`REG_COUNT, value);
        checkValue("count after reset", 32'd0, value);
        writeReg(`REG_BASE, 32'hFFABCDEF);
        readReg(`REG_BASE, value);
        checkValue("base readback", 32'h00ABCDEF, value);
        readReg(8'h10, value);
        checkValue("unknown offset", 32'd0, value);

        // Normal boot of 40 words
        startBoot(24'd16);
        pollUntilFinished(value);
        checkValue("status after boot", 32'h2, value);
        readReg(`REG_COUNT, value);
        checkValue("count after boot", 32'd40, value);
        checkValue("hold after boot", 32'd0, {31'd0, cpuHold});
        checkRamRange("first boot", 0, 39, 24'd16);

        // Processor write after boot reaches RAM
        writeBus(ramAddress(16'd7), 32'h5A5A1234);
        readRamWord(7, value);
        checkValue("processor write", 32'h5A5A1234, value);

        // Pixel write, low half aliases RAM word 5
        writeBus(pixelAddress(8'h12, 8'h34, 16'h0005), 32'h000000C3);
        writeBus(pixelAddress(8'hFF, 8'h00, 16'h0009), 32'h0000007E);
        pixelRow = 8'h12;
        pixelCol = 8'h34;
        stepCycle();
        checkValue("pixel 12,34", 32'hC3, {24'd0, pixelColor});
        pixelRow = 8'hFF;
        pixelCol = 8'h00;
        // Old pixel stays until the next edge
        #1;
        checkValue("pixel before display edge", 32'hC3, {24'd0, pixelColor});
        stepCycle();
        checkValue("pixel ff,00", 32'h7E, {24'd0, pixelColor});
        checkRamRange("ram after pixel writes", 5, 5, 24'd16);
        checkRamRange("ram after pixel writes", 9, 9, 24'd16);

        // Oversized image, then processor writes while held
        startBoot(24'd100);
        pollUntilFinished(value);
        checkValue("status after size error", 32'h4, value);
        readReg(`REG_COUNT, value);
        checkValue("count after size error", 32'd0, value);
        checkValue("hold after size error", 32'd1, {31'd0, cpuHold});
        writeBus(ramAddress(16'd20), 32'hFFFF0000);
        writeBus(ramAddress(16'd33), 32'h0000FFFF);

        // Recovery boot of 12 words leaves words 12 to 39 from the first image
        startBoot(24'd200);
        pollUntilFinished(value);
        checkValue("status after recovery", 32'h2, value);
        readReg(`REG_COUNT, value);
        checkValue("count after recovery", 32'd12, value);
        checkValue("hold after recovery", 32'd0, {31'd0, cpuHold});
        checkRamRange("recovery boot", 0, 11, 24'd200);
        checkRamRange("untouched words", 12, 39, 24'd16);

        $display("All checks passed");
        $finish;
    end

endmodule

// File: bootSoc.f
+incdir+.
bootSocPkg.sv
sdWordReader.sv
bootLoader.sv
bootRegs.sv
programMemory.sv
frameBuffer.sv
bootSocTop.sv
bootSoc_props.sv
bootSocTb.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= bootSoc.f
TOP       ?= bootSocTb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= All checks passed

SOURCES := $(filter %.sv,$(shell cat $(FILELIST))) bootSoc_defines.svh
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
